// File: Bender.yml
package:
  name: rv32i_exec_slice

sources:
  - source/exec_pkg.sv
  - source/alu.sv
  - source/instr_decoder.sv
  - source/register_file.sv
  - source/apb_exec_ctrl.sv
  - source/exec_top.sv
  - target: simulation
    files:
      - verification/exec_tb.sv

// File: flist.f
source/exec_pkg.sv
source/alu.sv
source/instr_decoder.sv
source/register_file.sv
source/apb_exec_ctrl.sv
source/exec_top.sv
verification/exec_tb.sv

// File: source/alu.sv
`timescale 1ns/1ps

module alu (
    input  exec_pkg::word_t      src_a_i,
    input  exec_pkg::word_t      src_b_i,
    input  exec_pkg::alu_op_e    alu_op_i,
    input  exec_pkg::branch_op_e branch_op_i,
    output exec_pkg::word_t      result_o,
    output logic                 branch_o
);

    logic signed [exec_pkg::xlen-1:0] src_a_signed;
    logic signed [exec_pkg::xlen-1:0] src_b_signed;
    logic [exec_pkg::shamt_w-1:0]     shamt;
    logic                             cmp_taken;
    logic                             is_jump;

    assign src_a_signed = src_a_i;
    assign src_b_signed = src_b_i;
    assign shamt        = src_b_i[exec_pkg::shamt_w-1:0];

    always_comb begin
        case (branch_op_i)
            exec_pkg::br_eq: begin
                cmp_taken = (src_a_i == src_b_i);
            end
            exec_pkg::br_ne: begin
                cmp_taken = (src_a_i != src_b_i);
            end
            exec_pkg::br_lt: begin
                cmp_taken = (src_a_signed < src_b_signed);
            end
            exec_pkg::br_ge: begin
                cmp_taken = (src_a_signed >= src_b_signed);
            end
            exec_pkg::br_ltu: begin
                cmp_taken = (src_a_i < src_b_i);
            end
            exec_pkg::br_geu: begin
                cmp_taken = (src_a_i >= src_b_i);
            end
            default: begin
                cmp_taken = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (alu_op_i)
            exec_pkg::alu_add:  result_o = src_a_i + src_b_i;
            exec_pkg::alu_sub:  result_o = src_a_i - src_b_i;
            exec_pkg::alu_and:  result_o = src_a_i & src_b_i;
            exec_pkg::alu_or:   result_o = src_a_i | src_b_i;
            exec_pkg::alu_xor:  result_o = src_a_i ^ src_b_i;
            exec_pkg::alu_slt: begin
                result_o = (src_a_signed < src_b_signed) ? 32'd1 : 32'd0;
            end
            exec_pkg::alu_sltu: begin
                result_o = (src_a_i < src_b_i) ? 32'd1 : 32'd0;
            end
            exec_pkg::alu_srl:  result_o = src_a_i >> shamt;
            exec_pkg::alu_sll:  result_o = src_a_i << shamt;
            exec_pkg::alu_sra:  result_o = src_a_signed >>> shamt;
            // link value arrives on operand b
            exec_pkg::alu_jal:  result_o = src_b_i;
            exec_pkg::alu_jalr: result_o = src_a_i + src_b_i;
            default:            result_o = '0;
        endcase
    end

    // jumps always count as taken
    assign is_jump  = (alu_op_i == exec_pkg::alu_jal) || (alu_op_i == exec_pkg::alu_jalr);
    assign branch_o = is_jump | cmp_taken;

endmodule

// File: source/apb_exec_ctrl.sv
`timescale 1ns/1ps

module apb_exec_ctrl (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  exec_pkg::apb_addr_t  paddr_i,
    input  logic                 psel_i,
    input  logic                 penable_i,
    input  logic                 pwrite_i,
    input  exec_pkg::word_t      pwdata_i,
    output exec_pkg::word_t      prdata_o,
    output logic                 pready_o,
    output logic                 pslverr_o,
    output exec_pkg::word_t      instr_o,
    input  exec_pkg::alu_op_e    alu_op_i,
    input  exec_pkg::branch_op_e branch_op_i,
    input  exec_pkg::src_a_sel_e src_a_sel_i,
    input  exec_pkg::src_b_sel_e src_b_sel_i,
    input  exec_pkg::word_t      imm_i,
    input  exec_pkg::reg_idx_t   rs1_i,
    input  exec_pkg::reg_idx_t   rs2_i,
    input  exec_pkg::reg_idx_t   rd_i,
    input  logic                 reg_write_i,
    input  logic                 is_branch_i,
    input  logic                 illegal_i,
    output exec_pkg::reg_idx_t   raddr_a_o,
    output exec_pkg::reg_idx_t   raddr_b_o,
    input  exec_pkg::word_t      rdata_a_i,
    input  exec_pkg::word_t      rdata_b_i,
    output logic                 we_o,
    output exec_pkg::reg_idx_t   waddr_o,
    output exec_pkg::word_t      wdata_o,
    output exec_pkg::word_t      src_a_o,
    output exec_pkg::word_t      src_b_o,
    input  exec_pkg::word_t      alu_result_i,
    input  logic                 branch_i
);

    typedef enum logic {st_idle, st_execute} exec_state_e;

    exec_state_e     state_q;
    exec_pkg::word_t pc_q;
    exec_pkg::word_t instr_q;
    logic [1:0]      status_q;
    exec_pkg::word_t pc_plus4;
    exec_pkg::word_t next_pc;
    logic            access;
    logic            in_regs;
    logic            mapped;
    logic            instr_wr;
    logic            is_jalr;
    logic            taken;
    logic            executing;

    assign access    = psel_i & penable_i;
    assign executing = (state_q == st_execute);
    assign in_regs   = (paddr_i[11:7] == exec_pkg::addr_regs_base[11:7]) && (paddr_i[1:0] == 2'b00);
    assign mapped    = in_regs || paddr_i == exec_pkg::addr_pc
                       || paddr_i == exec_pkg::addr_instr || paddr_i == exec_pkg::addr_status;
    assign instr_wr  = access && pwrite_i && paddr_i == exec_pkg::addr_instr;

    // instruction writes hold one wait cycle while the word is latched
    assign pready_o  = access && !(instr_wr && !executing);
    assign pslverr_o = access && !mapped;

    always_comb begin
        prdata_o = '0;
        if (in_regs) begin
            prdata_o = rdata_a_i;
        end else if (paddr_i == exec_pkg::addr_pc) begin
            prdata_o = pc_q;
        end else if (paddr_i == exec_pkg::addr_instr) begin
            prdata_o = instr_q;
        end else if (paddr_i == exec_pkg::addr_status) begin
            prdata_o = {30'b0, status_q};
        end
    end

    assign instr_o   = instr_q;
    assign raddr_a_o = executing ? rs1_i : paddr_i[6:2];
    assign raddr_b_o = rs2_i;

    assign pc_plus4 = pc_q + 32'd4;
    assign src_a_o  = (src_a_sel_i == exec_pkg::src_a_rs1) ? rdata_a_i
                    : (src_a_sel_i == exec_pkg::src_a_pc)  ? pc_q : '0;
    assign src_b_o  = (src_b_sel_i == exec_pkg::src_b_rs2) ? rdata_b_i
                    : (src_b_sel_i == exec_pkg::src_b_imm) ? imm_i : pc_plus4;

    // comparator output is meaningless for non-branch ops
    assign is_jalr = (alu_op_i == exec_pkg::alu_jalr);
    assign taken   = branch_i && !illegal_i
                     && (is_branch_i || is_jalr || alu_op_i == exec_pkg::alu_jal);
    assign next_pc = illegal_i ? pc_q
                   : is_jalr   ? {alu_result_i[31:1], 1'b0}
                   : taken     ? pc_q + imm_i : pc_plus4;

    // execute and host window writes share the one write port
    assign we_o    = executing ? reg_write_i
                               : (access && pwrite_i && in_regs);
    assign waddr_o = executing ? rd_i : paddr_i[6:2];
    assign wdata_o = !executing ? pwdata_i : (is_jalr ? pc_plus4 : alu_result_i);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q  <= st_idle;
            pc_q     <= '0;
            instr_q  <= '0;
            status_q <= '0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (access && pwrite_i && paddr_i == exec_pkg::addr_pc) begin
                        pc_q <= pwdata_i;
                    end
                    if (instr_wr) begin
                        instr_q <= pwdata_i;
                        state_q <= st_execute;
                    end
                end
                default: begin
                    pc_q     <= next_pc;
                    status_q <= {illegal_i, taken};
                    state_q  <= st_idle;
                end
            endcase
        end
    end

    a_instr_wait: assert property (
        @(posedge clk_i) disable iff (reset_i)
        instr_wr && pready_o |-> $past(instr_wr && !pready_o)
    ) else $error("apb_exec_ctrl: instruction write completed without wait cycle");

    a_no_illegal_write: assert property (
        @(posedge clk_i) disable iff (reset_i)
        executing && illegal_i |-> !we_o
    ) else $error("apb_exec_ctrl: register write on illegal instruction");

endmodule

// File: source/exec_pkg.sv
package exec_pkg;

    localparam int xlen      = 32;
    localparam int shamt_w   = 5;
    localparam int reg_idx_w = 5;

    typedef logic [xlen-1:0]      word_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;
    typedef logic [11:0]          apb_addr_t;

    // ALU control field encodings
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sub  = 4'b0001,
        alu_and  = 4'b0010,
        alu_or   = 4'b0011,
        alu_xor  = 4'b0100,
        alu_slt  = 4'b0101,
        alu_sltu = 4'b0110,
        alu_srl  = 4'b0111,
        alu_sll  = 4'b1000,
        alu_sra  = 4'b1001,
        alu_jal  = 4'b1011,
        alu_jalr = 4'b1100
    } alu_op_e;

    // same as branch funct3
    typedef enum logic [2:0] {
        br_eq  = 3'b000,
        br_ne  = 3'b001,
        br_lt  = 3'b100,
        br_ge  = 3'b101,
        br_ltu = 3'b110,
        br_geu = 3'b111
    } branch_op_e;

    typedef enum logic [1:0] {
        src_a_rs1,
        src_a_pc,
        src_a_zero
    } src_a_sel_e;

    typedef enum logic [1:0] {
        src_b_rs2,
        src_b_imm,
        src_b_pc4
    } src_b_sel_e;

    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    localparam apb_addr_t addr_pc        = 12'h000;
    localparam apb_addr_t addr_instr     = 12'h004;
    localparam apb_addr_t addr_status    = 12'h008;
    localparam apb_addr_t addr_regs_base = 12'h080;

endpackage

// File: source/exec_top.sv
`timescale 1ns/1ps

module exec_top (
    input  logic                clk_i,
    input  logic                reset_i,
    input  exec_pkg::apb_addr_t paddr_i,
    input  logic                psel_i,
    input  logic                penable_i,
    input  logic                pwrite_i,
    input  exec_pkg::word_t     pwdata_i,
    output exec_pkg::word_t     prdata_o,
    output logic                pready_o,
    output logic                pslverr_o
);

    exec_pkg::word_t      instr, imm, rdata_a, rdata_b, wdata, src_a, src_b, alu_result;
    exec_pkg::alu_op_e    alu_op;
    exec_pkg::branch_op_e branch_op;
    exec_pkg::src_a_sel_e src_a_sel;
    exec_pkg::src_b_sel_e src_b_sel;
    exec_pkg::reg_idx_t   rs1, rs2, rd, raddr_a, raddr_b, waddr;
    logic                 reg_write, is_branch, illegal, we, branch;

    apb_exec_ctrl u_ctrl (
        .clk_i, .reset_i, .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i,
        .prdata_o, .pready_o, .pslverr_o,
        .instr_o(instr), .alu_op_i(alu_op), .branch_op_i(branch_op),
        .src_a_sel_i(src_a_sel), .src_b_sel_i(src_b_sel), .imm_i(imm),
        .rs1_i(rs1), .rs2_i(rs2), .rd_i(rd), .reg_write_i(reg_write),
        .is_branch_i(is_branch), .illegal_i(illegal),
        .raddr_a_o(raddr_a), .raddr_b_o(raddr_b), .rdata_a_i(rdata_a), .rdata_b_i(rdata_b),
        .we_o(we), .waddr_o(waddr), .wdata_o(wdata),
        .src_a_o(src_a), .src_b_o(src_b), .alu_result_i(alu_result), .branch_i(branch)
    );

    instr_decoder u_decoder (
        .instr_i(instr), .alu_op_o(alu_op), .branch_op_o(branch_op),
        .src_a_sel_o(src_a_sel), .src_b_sel_o(src_b_sel), .imm_o(imm),
        .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd), .reg_write_o(reg_write),
        .is_branch_o(is_branch), .illegal_o(illegal)
    );

    register_file u_regs (
        .clk_i, .reset_i,
        .raddr_a_i(raddr_a), .raddr_b_i(raddr_b), .rdata_a_o(rdata_a), .rdata_b_o(rdata_b),
        .we_i(we), .waddr_i(waddr), .wdata_i(wdata)
    );

    alu u_alu (
        .src_a_i(src_a), .src_b_i(src_b), .alu_op_i(alu_op), .branch_op_i(branch_op),
        .result_o(alu_result), .branch_o(branch)
    );

endmodule

// File: source/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  exec_pkg::word_t      instr_i,
    output exec_pkg::alu_op_e    alu_op_o,
    output exec_pkg::branch_op_e branch_op_o,
    output exec_pkg::src_a_sel_e src_a_sel_o,
    output exec_pkg::src_b_sel_e src_b_sel_o,
    output exec_pkg::word_t      imm_o,
    output exec_pkg::reg_idx_t   rs1_o,
    output exec_pkg::reg_idx_t   rs2_o,
    output exec_pkg::reg_idx_t   rd_o,
    output logic                 reg_write_o,
    output logic                 is_branch_o,
    output logic                 illegal_o
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            funct7_alt;
    logic            f7_checked;
    logic            alt_allowed;
    exec_pkg::word_t imm_itype;
    exec_pkg::word_t imm_utype;
    exec_pkg::word_t imm_btype;
    exec_pkg::word_t imm_jtype;

    assign opcode     = instr_i[6:0];
    assign funct3     = instr_i[14:12];
    assign funct7     = instr_i[31:25];
    assign funct7_alt = (funct7 == 7'b0100000);
    assign rd_o       = instr_i[11:7];
    assign rs1_o      = instr_i[19:15];
    assign rs2_o      = instr_i[24:20];

    assign imm_itype = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_utype = {instr_i[31:12], 12'b0};
    assign imm_btype = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                        instr_i[11:8], 1'b0};
    assign imm_jtype = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                        instr_i[30:21], 1'b0};

    // funct7 only matters for shifts and register forms; sub and sra take the alt value
    assign f7_checked  = (opcode == exec_pkg::op_reg) || (funct3 == 3'b001)
                         || (funct3 == 3'b101);
    assign alt_allowed = (funct3 == 3'b101)
                         || ((funct3 == 3'b000) && (opcode == exec_pkg::op_reg));

    always_comb begin
        alu_op_o    = exec_pkg::alu_add;
        branch_op_o = exec_pkg::br_eq;
        src_a_sel_o = exec_pkg::src_a_rs1;
        src_b_sel_o = exec_pkg::src_b_rs2;
        imm_o       = '0;
        reg_write_o = 1'b0;
        is_branch_o = 1'b0;
        illegal_o   = 1'b0;
        case (opcode)
            exec_pkg::op_lui, exec_pkg::op_auipc: begin
                src_a_sel_o = (opcode == exec_pkg::op_lui) ? exec_pkg::src_a_zero
                                                           : exec_pkg::src_a_pc;
                src_b_sel_o = exec_pkg::src_b_imm;
                imm_o       = imm_utype;
                reg_write_o = 1'b1;
            end
            exec_pkg::op_jal: begin
                alu_op_o    = exec_pkg::alu_jal;
                src_a_sel_o = exec_pkg::src_a_pc;
                src_b_sel_o = exec_pkg::src_b_pc4;
                imm_o       = imm_jtype;
                reg_write_o = 1'b1;
            end
            exec_pkg::op_jalr: begin
                alu_op_o    = exec_pkg::alu_jalr;
                src_b_sel_o = exec_pkg::src_b_imm;
                imm_o       = imm_itype;
                reg_write_o = 1'b1;
                illegal_o   = (funct3 != 3'b000);
            end
            exec_pkg::op_branch: begin
                is_branch_o = 1'b1;
                imm_o       = imm_btype;
                if (funct3 == 3'b010 || funct3 == 3'b011) begin
                    illegal_o = 1'b1;
                end else begin
                    branch_op_o = exec_pkg::branch_op_e'(funct3);
                end
            end
            exec_pkg::op_imm, exec_pkg::op_reg: begin
                reg_write_o = 1'b1;
                if (opcode == exec_pkg::op_imm) begin
                    src_b_sel_o = exec_pkg::src_b_imm;
                    imm_o       = imm_itype;
                end
                case (funct3)
                    3'b000: begin
                        alu_op_o = (opcode == exec_pkg::op_reg && funct7_alt)
                                   ? exec_pkg::alu_sub : exec_pkg::alu_add;
                    end
                    3'b001:  alu_op_o = exec_pkg::alu_sll;
                    3'b010:  alu_op_o = exec_pkg::alu_slt;
                    3'b011:  alu_op_o = exec_pkg::alu_sltu;
                    3'b100:  alu_op_o = exec_pkg::alu_xor;
                    3'b101:  alu_op_o = funct7_alt ? exec_pkg::alu_sra : exec_pkg::alu_srl;
                    3'b110:  alu_op_o = exec_pkg::alu_or;
                    default: alu_op_o = exec_pkg::alu_and;
                endcase
                if (f7_checked && funct7 != 7'b0 && !(funct7_alt && alt_allowed)) begin
                    illegal_o = 1'b1;
                end
            end
            // loads, stores, fences and system land here
            default: illegal_o = 1'b1;
        endcase
        if (illegal_o) begin
            reg_write_o = 1'b0;
        end
    end

endmodule

// File: source/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic               clk_i,
    input  logic               reset_i,
    input  exec_pkg::reg_idx_t raddr_a_i,
    input  exec_pkg::reg_idx_t raddr_b_i,
    output exec_pkg::word_t    rdata_a_o,
    output exec_pkg::word_t    rdata_b_o,
    input  logic               we_i,
    input  exec_pkg::reg_idx_t waddr_i,
    input  exec_pkg::word_t    wdata_i
);

    // x0 has no storage
    exec_pkg::word_t regs [1:31];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

// File: verification/exec_tb.sv
`timescale 1ns/1ps

module exec_tb;

    logic                clk_i;
    logic                reset_i;
    exec_pkg::apb_addr_t paddr_i;
    logic                psel_i;
    logic                penable_i;
    logic                pwrite_i;
    exec_pkg::word_t     pwdata_i;
    exec_pkg::word_t     prdata_o;
    logic                pready_o;
    logic                pslverr_o;

    // one entry per transfer line of the data file
    string               names[$];
    bit                  writes[$];
    exec_pkg::apb_addr_t addrs[$];
    exec_pkg::word_t     values[$];
    bit                  errs[$];

    int cycle_count = 0;
    int cycle_limit = 0;

    exec_top dut (
        .clk_i, .reset_i, .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i,
        .prdata_o, .pready_o, .pslverr_o
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s: expected %h, actual %h", test_name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic load_testdata();
        int                  fd;
        int                  rc;
        int                  c;
        string               tok;
        string               kind;
        exec_pkg::apb_addr_t addr;
        exec_pkg::word_t     value;
        logic                err;
        fd = $fopen("verification/exec_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/exec_testdata.txt");
            $display("ERRORS FOUND");
            $fatal(1, "missing test data");
        end
        rc = $fscanf(fd, "%s", tok);
        while (rc == 1) begin
            if (tok.getc(0) == "#") begin
                // skip the rest of a comment line
                c = $fgetc(fd);
                while (c != "\n" && c != -1) begin
                    c = $fgetc(fd);
                end
            end else if ($fscanf(fd, "%s %h %h %h", kind, addr, value, err) != 4
                         || (kind != "W" && kind != "R")) begin
                $display("malformed test data line starting with %s", tok);
                $display("ERRORS FOUND");
                $fatal(1, "bad test data");
            end else begin
                names.push_back(tok);
                writes.push_back(kind == "W");
                addrs.push_back(addr);
                values.push_back(value);
                errs.push_back(err);
            end
            rc = $fscanf(fd, "%s", tok);
        end
        $fclose(fd);
    endtask

    task automatic apb_transfer(input string test_name, input bit write,
                                input exec_pkg::apb_addr_t addr, input exec_pkg::word_t value,
                                input bit exp_err);
        int              access_cycles;
        int              exp_cycles;
        logic            done;
        exec_pkg::word_t rdata;
        logic            err;
        access_cycles = 0;
        done          = 1'b0;
        // instruction writes take one wait cycle, everything else none
        exp_cycles    = (write && addr == exec_pkg::addr_instr) ? 2 : 1;
        @(posedge clk_i);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= write;
        paddr_i   <= addr;
        pwdata_i  <= write ? value : '0;
        @(posedge clk_i);
        penable_i <= 1'b1;
        while (!done) begin
            @(negedge clk_i);
            access_cycles++;
            done  = (pready_o === 1'b1);
            rdata = prdata_o;
            err   = pslverr_o;
            @(posedge clk_i);
        end
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
        check_value({test_name, " pslverr"}, exp_err, err);
        check_value({test_name, " access cycles"}, exp_cycles, access_cycles);
        if (!write && !exp_err) begin
            check_value(test_name, value, rdata);
        end
    endtask

    // bus watchdog
    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("timeout: the bus hung, no transfer finished within %0d cycles", cycle_limit);
        $display("ERRORS FOUND");
        $fatal(1, "timeout");
    end

    initial begin
        reset_i   = 1'b1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = '0;
        pwdata_i  = '0;
        load_testdata();
        cycle_limit = 6 * names.size() + 20;
        repeat (3) @(posedge clk_i);
        reset_i <= 1'b0;
        foreach (names[i]) begin
            apb_transfer(names[i], writes[i], addrs[i], values[i], errs[i]);
        end
        @(posedge clk_i);
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: verification/exec_testdata.txt
# name  kind (W write, R read)  address  write data or expected read data  expected pslverr
# all numbers in hex; x1=-1 x2=1 x3=0x24 x4=0x80000010 after preload, pc starts at 0x100
preload_x1 W 084 ffffffff 0
preload_x2 W 088 00000001 0
preload_x3 W 08c 00000024 0
preload_x4 W 090 80000010 0
x0_apb_write W 080 12345678 0
x0_apb_read R 080 00000000 0
set_pc W 000 00000100 0
add_exec W 004 002082b3 0
add_rd R 094 00000000 0
sub_exec W 004 40110333 0
sub_rd R 098 00000002 0
and_exec W 004 0040f3b3 0
and_rd R 09c 80000010 0
or_exec W 004 00316433 0
or_rd R 0a0 00000025 0
xor_exec W 004 002244b3 0
xor_rd R 0a4 80000011 0
slt_exec W 004 0020a533 0
slt_rd R 0a8 00000001 0
sltu_exec W 004 0020b5b3 0
sltu_rd R 0ac 00000000 0
addi_exec W 004 ffb10613 0
addi_rd R 0b0 fffffffc 0
andi_exec W 004 7f00f693 0
andi_rd R 0b4 000007f0 0
sltiu_exec W 004 fff13713 0
sltiu_rd R 0b8 00000001 0
ori_exec W 004 10016793 0
ori_rd R 0bc 00000101 0
xori_exec W 004 fff24813 0
xori_rd R 0c0 7fffffef 0
slti_exec W 004 0000a893 0
slti_rd R 0c4 00000001 0
lui_exec W 004 abcde937 0
lui_rd R 0c8 abcde000 0
auipc_exec W 004 00001997 0
auipc_rd R 0cc 00001138 0
sll_exec W 004 00311a33 0
sll_rd R 0d0 00000010 0
sra_exec W 004 40325ab3 0
sra_rd R 0d4 f8000001 0
srl_exec W 004 00325b33 0
srl_rd R 0d8 08000001 0
srai_exec W 004 41f25b93 0
srai_rd R 0dc ffffffff 0
slli_exec W 004 01f09c13 0
slli_rd R 0e0 80000000 0
srli_exec W 004 00425c93 0
srli_rd R 0e4 08000001 0
beq_exec W 004 00210863 0
beq_pc R 000 00000164 0
beq_status R 008 00000001 0
bne_exec W 004 00211863 0
bne_pc R 000 00000168 0
bne_status R 008 00000000 0
blt_exec W 004 fe20cce3 0
blt_pc R 000 00000160 0
bge_exec W 004 0020d863 0
bge_pc R 000 00000164 0
bltu_exec W 004 0020e863 0
bltu_pc R 000 00000168 0
bgeu_exec W 004 0020f863 0
bgeu_pc R 000 00000178 0
jal_exec W 004 02000d6f 0
jal_rd R 0e8 0000017c 0
jal_pc R 000 00000198 0
jal_status R 008 00000001 0
jalr_exec W 004 00520de7 0
jalr_rd R 0ec 0000019c 0
jalr_pc R 000 80000014 0
load_exec W 004 0000a103 0
load_status R 008 00000002 0
load_pc R 000 80000014 0
load_x2_kept R 088 00000001 0
x0_instr_exec W 004 00510013 0
x0_instr_read R 080 00000000 0
instr_readback R 004 00510013 0
unmapped_write W 00c 0000beef 1
unmapped_read R 100 00000000 1
